// File: gb_sysbus.f
+incdir+testbench
src/gb_map_pkg.sv
src/gb_irq_pkg.sv
src/gb_cpu_bus_if.sv
src/gb_ram.sv
src/gb_bus_ctrl.sv
src/gb_irq_ctrl.sv
src/gb_sys_regs.sv
src/gb_int_mem.sv
src/gb_ext_bus.sv
src/gb_sysbus.sv
testbench/tb_gb_sysbus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, then search the log for the fail line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_gb_sysbus \
	-f gb_sysbus.f -o tb_gb_sysbus \
	&& ./obj_dir/tb_gb_sysbus > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0

// File: src/gb_bus_ctrl.sv
// cpu bus front end: write edge strobe, drives the decoded bus and picks the cpu read byte
`timescale 1ns/1ps

module gb_bus_ctrl (
	input  logic                 clk_sys,
	input  logic                 reset_ss,
	input  logic                 ce_i,
	input  gb_map_pkg::addr_t    cpu_addr_i,
	input  gb_map_pkg::byte_t    cpu_do_i,
	input  logic                 cpu_rd_n_i,
	input  logic                 cpu_wr_n_i,
	input  logic                 irq_ack_i,	// vector cycle
	input  gb_irq_pkg::irq_vec_t irq_vec_i,
	input  gb_map_pkg::byte_t    irq_rdata_i,
	input  gb_map_pkg::byte_t    sys_rdata_i,
	input  logic                 sys_hit_i,
	input  gb_map_pkg::byte_t    mem_rdata_i,
	input  logic                 mem_hit_i,
	input  gb_map_pkg::byte_t    ext_rdata_i,
	input  logic                 ext_hit_i,
	output gb_map_pkg::byte_t    cpu_di_o,
	gb_cpu_bus_if.master         bus
);
	import gb_map_pkg::*;

	logic old_wr_n;	// wr_n seen at the last ce cycle
	logic irq_hit;

	// --------------------
	// write edge
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			old_wr_n <= 1'b0;	// no strobe straight out of reset
		end else if (ce_i) begin
			old_wr_n <= cpu_wr_n_i;
		end
	end

	assign bus.addr   = cpu_addr_i;
	assign bus.wdata  = cpu_do_i;
	assign bus.wr_stb = ce_i & old_wr_n & ~cpu_wr_n_i;	// high to low, one ce cycle
	assign bus.rd     = ~cpu_rd_n_i;
	assign bus.ce     = ce_i;

	// IF and IE sit in the irq block, which reports no hit of its own
	assign irq_hit = (cpu_addr_i == REG_IF) || (cpu_addr_i == REG_IE);

	// --------------------
	// read mux
	// --------------------
	always_comb begin
		if (irq_ack_i) begin
			cpu_di_o = irq_vec_i;	// ack beats any address
		end else if (irq_hit) begin
			cpu_di_o = irq_rdata_i;
		end else if (sys_hit_i) begin
			cpu_di_o = sys_rdata_i;
		end else if (mem_hit_i) begin
			cpu_di_o = mem_rdata_i;	// zp or wram, registered
		end else if (ext_hit_i) begin
			cpu_di_o = ext_rdata_i;	// cartridge or open bus
		end else begin
			cpu_di_o = OPEN_BYTE;
		end
	end

endmodule

// File: src/gb_cpu_bus_if.sv
// decoded cpu access, driven by gb_bus_ctrl and read by the register and memory blocks
`timescale 1ns/1ps

interface gb_cpu_bus_if;
	import gb_map_pkg::*;

	addr_t addr;	// cpu address, straight through
	byte_t wdata;	// cpu write data
	logic  wr_stb;	// one clk_sys pulse per cpu write
	logic  rd;	// read level, active high
	logic  ce;	// cpu clock enable

	// one driver, several listeners
	modport master (
		output addr,
		output wdata,
		output wr_stb,
		output rd,
		output ce
	);

	modport slave (
		input addr,
		input wdata,
		input wr_stb,
		input rd,
		input ce
	);

endinterface

// File: src/gb_ext_bus.sv
// cartridge bus: address, A15, chip select, strobes and open-bus decay of the data lines
`timescale 1ns/1ps

module gb_ext_bus (
	input  logic              clk_sys,
	input  logic              reset_ss,
	input  gb_map_pkg::byte_t cart_do_i,
	input  logic              cart_oe_i,	// cartridge drives data
	output logic [14:0]       ext_bus_addr_o,
	output logic              ext_bus_a15_o,
	output logic              ncs_o,
	output logic              cart_rd_o,
	output logic              cart_wr_o,
	output gb_map_pkg::byte_t cart_di_o,
	output gb_map_pkg::byte_t rdata_o,
	output logic              hit_o,
	gb_cpu_bus_if.slave       bus
);
	import gb_map_pkg::*;

	localparam int CNT_W = $clog2(OPEN_BUS_DECAY + 1);

	logic             sel_rom;
	logic             sel_cram;
	logic             drive;	// cart owns the data lines
	logic [CNT_W-1:0] idle_cnt;
	byte_t            bus_latch;	// last byte seen on the lines

	assign sel_rom  = ~bus.addr[15];	// 0000-7fff
	assign sel_cram = bus.addr[15:13] == 3'b101;	// a000-bfff
	assign hit_o    = sel_rom | sel_cram;

	assign ext_bus_addr_o = bus.addr[14:0];
	assign ext_bus_a15_o  = bus.addr[15];
	assign ncs_o          = ~sel_cram;	// wram has its own bus
	assign cart_rd_o      = hit_o & bus.rd;
	assign cart_wr_o      = hit_o & bus.wr_stb;
	assign cart_di_o      = bus.wdata;

	assign drive   = hit_o & cart_oe_i;
	assign rdata_o = drive ? cart_do_i : bus_latch;

	// --------------------
	// open bus
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			idle_cnt  <= CNT_W'(OPEN_BUS_DECAY);	// start fully decayed
			bus_latch <= OPEN_BYTE;
		end else if (bus.ce) begin
			if (drive) begin
				bus_latch <= cart_do_i;
				idle_cnt  <= '0;
			end else if (idle_cnt != CNT_W'(OPEN_BUS_DECAY)) begin
				idle_cnt <= idle_cnt + 1'b1;
				if (idle_cnt == CNT_W'(OPEN_BUS_DECAY - 1))
					bus_latch <= OPEN_BYTE;	// pull-ups win
			end
		end
	end

endmodule

// File: src/gb_int_mem.sv
// internal memories: zero-page RAM at FF80 and banked work RAM at C000 with its echo
`timescale 1ns/1ps

module gb_int_mem #(
	parameter int WRAM_ADDR_W = 15,	// 13 for a two-bank build
	parameter int ZP_ADDR_W   = 7
) (
	input  logic              clk_sys,
	input  logic [2:0]        wram_bank_i,	// SVBK
	output gb_map_pkg::byte_t rdata_o,
	output logic              hit_o,
	gb_cpu_bus_if.slave       bus
);
	import gb_map_pkg::*;

	localparam int BANK_W = WRAM_ADDR_W - 12;	// 4 KiB banks

	logic                   sel_zp;
	logic                   sel_wram;
	logic [BANK_W-1:0]      bank;
	logic [WRAM_ADDR_W-1:0] wram_addr;
	byte_t                  zp_q;
	byte_t                  wram_q;

	assign sel_zp   = (bus.addr[15:7] == ZP_BASE[15:7]) && (bus.addr != REG_IE);
	assign sel_wram = (bus.addr[15:14] == 2'b11) && ~&bus.addr[13:9];	// c000-fdfff, echo included
	assign hit_o    = sel_zp | sel_wram;

	// bank 0 selects bank 1 in the upper half
	assign bank = (wram_bank_i[BANK_W-1:0] == '0) ? BANK_W'(1) : wram_bank_i[BANK_W-1:0];
	assign wram_addr = {bank & {BANK_W{bus.addr[12]}}, bus.addr[11:0]};	// lower half fixed bank 0

	gb_ram #(
		.ADDR_W (ZP_ADDR_W)
	) i_zp_ram (
		.clk_sys (clk_sys),
		.addr_i  (bus.addr[ZP_ADDR_W-1:0]),
		.we_i    (sel_zp & bus.wr_stb),
		.wdata_i (bus.wdata),
		.rdata_o (zp_q)
	);

	gb_ram #(
		.ADDR_W (WRAM_ADDR_W)
	) i_wram (
		.clk_sys (clk_sys),
		.addr_i  (wram_addr),
		.we_i    (sel_wram & bus.wr_stb),
		.wdata_i (bus.wdata),
		.rdata_o (wram_q)
	);

	assign rdata_o = sel_zp ? zp_q : wram_q;	// address held, select stays valid

endmodule

// File: src/gb_irq_ctrl.sv
// interrupt controller: IE/IF registers, event edge capture, acknowledge and vector generation
`timescale 1ns/1ps

module gb_irq_ctrl (
	input  logic                         clk_sys,
	input  logic                         reset_ss,
	input  logic [gb_irq_pkg::IRQ_N-1:0] irq_lines_i,	// event levels in IF bit order
	input  logic [3:0]                   joy_din_i,	// P10..P13, active low
	input  logic                         cpu_m1_n_i,
	input  logic                         cpu_iorq_n_i,
	output logic                         irq_ack_o,
	output gb_irq_pkg::irq_vec_t         irq_vec_o,
	output logic                         irq_n_o,
	output gb_map_pkg::byte_t            rdata_o,	// IF or IE
	gb_cpu_bus_if.slave                  bus
);
	import gb_map_pkg::*;
	import gb_irq_pkg::*;

	logic [7:0]       ie_r;	// all 8 bits kept
	logic [IRQ_N-1:0] if_r;
	logic [IRQ_N-1:0] old_lines;
	logic [3:0]       joy_d1;	// two-stage joypad sample
	logic [3:0]       joy_d2;
	logic             old_ack;
	logic [IRQ_N-1:0] pending;
	logic [IRQ_N-1:0] set_mask;
	logic [IRQ_N-1:0] clr_mask;	// top-priority pending bit
	logic             ack_end;

	assign irq_ack_o = ~cpu_iorq_n_i & ~cpu_m1_n_i;
	assign pending   = ie_r[IRQ_N-1:0] & if_r;
	assign irq_n_o   = ~|pending;	// upper IE bits have no flag
	assign ack_end   = old_ack & ~irq_ack_o;

	// --------------------
	// event capture
	// --------------------
	always_comb begin
		set_mask = irq_lines_i & ~old_lines;	// rising edges
		// any key line going low
		set_mask[IRQ_JOYPAD] = set_mask[IRQ_JOYPAD] | (|(~joy_d1 & joy_d2));
	end

	// walk from lowest priority up so the lowest index is left standing
	always_comb begin
		clr_mask  = '0;
		irq_vec_o = '0;	// nothing pending
		for (int i = IRQ_N - 1; i >= 0; i--) begin
			if (pending[i]) begin
				clr_mask    = '0;
				clr_mask[i] = 1'b1;
				irq_vec_o   = IRQ_VEC_BASE + irq_vec_t'(i * IRQ_VEC_STEP);
			end
		end
	end

	// --------------------
	// registers
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ie_r      <= '0;
			if_r      <= '0;
			old_lines <= '0;
			joy_d1    <= '0;
			joy_d2    <= '0;
			old_ack   <= 1'b0;
		end else if (bus.ce) begin
			old_lines <= irq_lines_i;
			joy_d1    <= joy_din_i;
			joy_d2    <= joy_d1;
			old_ack   <= irq_ack_o;

			// clear wins over a new event on the same bit
			if_r <= (if_r | set_mask) & ~({IRQ_N{ack_end}} & clr_mask);

			// cpu writes load directly
			if (bus.wr_stb && bus.addr == REG_IF)
				if_r <= bus.wdata[IRQ_N-1:0];
			if (bus.wr_stb && bus.addr == REG_IE)
				ie_r <= bus.wdata;
		end
	end

	// unused IF bits read as ones
	assign rdata_o = (bus.addr == REG_IF) ? {{(8 - IRQ_N){1'b1}}, if_r} : ie_r;

endmodule

// File: src/gb_irq_pkg.sv
// interrupt sources, vector table and priority order, imported by the interrupt logic and bus mux
package gb_irq_pkg;

	localparam int IRQ_N = 5;	// number of sources

	// index = IF/IE bit, lower index wins
	typedef enum logic [2:0] {
		IRQ_VBLANK = 3'd0,
		IRQ_LCDC   = 3'd1,
		IRQ_TIMER  = 3'd2,
		IRQ_SERIAL = 3'd3,
		IRQ_JOYPAD = 3'd4
	} irq_src_e;

	typedef logic [7:0] irq_vec_t;	// rst target placed on the bus

	// vector = base + step * source
	localparam irq_vec_t IRQ_VEC_BASE = 8'h40;
	localparam int       IRQ_VEC_STEP = 8;

endpackage

// File: src/gb_map_pkg.sv
// console bus memory map and register addresses, imported by the bus, register and memory blocks
package gb_map_pkg;

	typedef logic [15:0] addr_t;	// cpu address
	typedef logic [7:0]  byte_t;	// one data byte

	// --------------------
	// io registers
	// --------------------
	localparam addr_t REG_JOYP     = 16'hFF00;	// P1, select bits 5:4
	localparam addr_t REG_IF       = 16'hFF0F;	// interrupt flags
	localparam addr_t REG_KEY0     = 16'hFF4C;	// cpu mode, boot rom only
	localparam addr_t REG_KEY1     = 16'hFF4D;	// speed switch
	localparam addr_t REG_BOOT_OFF = 16'hFF50;	// boot rom disable
	localparam addr_t REG_SVBK     = 16'hFF70;	// work ram bank
	localparam addr_t REG_FF72     = 16'hFF72;
	localparam addr_t REG_FF73     = 16'hFF73;
	localparam addr_t REG_FF74     = 16'hFF74;	// colour mode only
	localparam addr_t REG_FF75     = 16'hFF75;	// bits 6:4 only
	localparam addr_t REG_IE       = 16'hFFFF;	// interrupt enable

	// --------------------
	// memories
	// --------------------
	localparam addr_t ZP_BASE = 16'hFF80;	// zero page runs up to fffe

	// cartridge data lines float high after a few idle cycles
	localparam int    OPEN_BUS_DECAY = 4;
	localparam byte_t OPEN_BYTE      = 8'hFF;	// unmapped read

endpackage

// File: src/gb_ram.sv
// single-port byte RAM with registered read, used for zero page and work RAM
`timescale 1ns/1ps

module gb_ram #(
	parameter int ADDR_W = 7
) (
	input  logic              clk_sys,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic              we_i,
	input  logic [7:0]        wdata_i,
	output logic [7:0]        rdata_o	// address of the previous edge
);

	logic [7:0] mem [2**ADDR_W];

	always_ff @(posedge clk_sys) begin
		if (we_i)
			mem[addr_i] <= wdata_i;
		rdata_o <= mem[addr_i];	// read before write
	end

endmodule

// File: src/gb_sys_regs.sv
// colour-model system registers: KEY0, KEY1, SVBK, boot rom disable, joypad select and spares
`timescale 1ns/1ps

module gb_sys_regs (
	input  logic              clk_sys,
	input  logic              reset_ss,
	input  logic              is_gbc_i,	// colour model
	input  logic              cpu_stop_i,
	input  logic [3:0]        joy_din_i,
	output gb_map_pkg::byte_t rdata_o,
	output logic              hit_o,
	output logic              gbc_mode_o,
	output logic [2:0]        wram_bank_o,
	output logic              speed_o,
	output logic              boot_rom_en_o,
	output logic [1:0]        joy_p54_o,
	gb_cpu_bus_if.slave       bus
);
	import gb_map_pkg::*;

	logic [1:0] key0;	// 00 colour, 01 mono compatible
	logic       boot_en;
	logic       speed;	// 1 = double rate
	logic       prepare;	// KEY1 bit 0
	logic [2:0] svbk;
	logic [1:0] p54;
	byte_t      ff72;
	byte_t      ff73;
	byte_t      ff74;
	logic [2:0] ff75;	// bits 6:4 only
	logic       gbc_mode;
	logic       sel_key0;
	logic       sel_key1;
	logic       sel_svbk;
	logic       sel_boot;
	logic       sel_joyp;
	logic       sel_ff72;
	logic       sel_ff73;
	logic       sel_ff74;
	logic       sel_ff75;

	assign gbc_mode = (key0 == 2'b00) | boot_en;	// boot rom always runs in colour mode

	// --------------------
	// decode
	// --------------------
	assign sel_key0 = is_gbc_i & boot_en & (bus.addr == REG_KEY0);	// locked once boot rom is off
	assign sel_key1 = is_gbc_i & gbc_mode & (bus.addr == REG_KEY1);
	assign sel_svbk = is_gbc_i & gbc_mode & (bus.addr == REG_SVBK);
	assign sel_boot = boot_en & (bus.addr == REG_BOOT_OFF);	// visible until disabled
	assign sel_joyp = bus.addr == REG_JOYP;
	assign sel_ff72 = is_gbc_i & (bus.addr == REG_FF72);
	assign sel_ff73 = is_gbc_i & (bus.addr == REG_FF73);
	assign sel_ff74 = is_gbc_i & gbc_mode & (bus.addr == REG_FF74);
	assign sel_ff75 = is_gbc_i & (bus.addr == REG_FF75);

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			key0    <= '0;
			boot_en <= 1'b1;
			speed   <= 1'b0;
			prepare <= 1'b0;
			svbk    <= '0;
			p54     <= '0;
			ff72    <= '0;
			ff73    <= '0;
			ff74    <= '0;
			ff75    <= '0;
		end else begin
			if (bus.wr_stb) begin
				if (sel_key0) key0 <= bus.wdata[3:2];
				if (sel_key1) prepare <= bus.wdata[0];
				if (sel_svbk) svbk <= bus.wdata[2:0];
				if (sel_joyp) p54 <= bus.wdata[5:4];
				if (sel_ff72) ff72 <= bus.wdata;
				if (sel_ff73) ff73 <= bus.wdata;
				if (sel_ff74) ff74 <= bus.wdata;
				if (sel_ff75) ff75 <= bus.wdata[6:4];
				// colour boot writes 11, mono boot writes 01
				if ((bus.addr == REG_BOOT_OFF) &&
				    ((is_gbc_i && bus.wdata == 8'h11) || (!is_gbc_i && bus.wdata[0])))
					boot_en <= 1'b0;
			end
			// STOP with prepare set flips the rate
			if (bus.ce && is_gbc_i && gbc_mode && prepare && cpu_stop_i) begin
				speed   <= ~speed;
				prepare <= 1'b0;
			end
		end
	end

	// --------------------
	// read back
	// --------------------
	always_comb begin
		hit_o = 1'b1;
		if (sel_key0)      rdata_o = {4'hF, key0, 2'b10};
		else if (sel_key1) rdata_o = {speed, 6'h3F, prepare};
		else if (sel_svbk) rdata_o = {5'h1F, svbk};
		else if (sel_joyp) rdata_o = {2'b11, p54, joy_din_i};
		else if (sel_boot) rdata_o = 8'h00;
		else if (sel_ff72) rdata_o = ff72;
		else if (sel_ff73) rdata_o = ff73;
		else if (sel_ff74) rdata_o = ff74;
		else if (sel_ff75) rdata_o = {1'b1, ff75, 4'hF};
		else begin
			rdata_o = OPEN_BYTE;
			hit_o   = 1'b0;
		end
	end

	assign gbc_mode_o    = gbc_mode;
	assign wram_bank_o   = svbk;	// 0 -> 1 mapping done in memory block
	assign speed_o       = speed;
	assign boot_rom_en_o = boot_en;
	assign joy_p54_o     = p54;

endmodule

// File: src/gb_sysbus.sv
// system bus glue top: cpu bus, interrupts, system registers, internal RAM and cartridge bus
`timescale 1ns/1ps

module gb_sysbus #(
	parameter int WRAM_ADDR_W = 15,	// 13 gives two wram banks
	parameter int ZP_ADDR_W   = 7
) (
	input  logic              clk_sys,
	input  logic              reset_ss,
	input  logic              ce_i,
	input  logic              is_gbc_i,
	input  gb_map_pkg::addr_t cpu_addr_i,
	input  gb_map_pkg::byte_t cpu_do_i,
	input  logic              cpu_rd_n_i,
	input  logic              cpu_wr_n_i,
	input  logic              cpu_m1_n_i,
	input  logic              cpu_iorq_n_i,
	input  logic              cpu_stop_i,
	input  logic              vblank_irq_i,
	input  logic              video_irq_i,
	input  logic              timer_irq_i,
	input  logic              serial_irq_i,
	input  logic [3:0]        joy_din_i,
	input  gb_map_pkg::byte_t cart_do_i,
	input  logic              cart_oe_i,
	output gb_map_pkg::byte_t cpu_di_o,
	output logic              irq_n_o,
	output logic              speed_o,
	output logic              boot_rom_en_o,
	output logic [1:0]        joy_p54_o,
	output logic [14:0]       ext_bus_addr_o,
	output logic              ext_bus_a15_o,
	output logic              ncs_o,
	output logic              cart_rd_o,
	output logic              cart_wr_o,
	output gb_map_pkg::byte_t cart_di_o
);
	import gb_map_pkg::*;
	import gb_irq_pkg::*;

	gb_cpu_bus_if bus ();

	logic       irq_ack;
	irq_vec_t   irq_vec;
	byte_t      irq_rdata;
	byte_t      sys_rdata;
	logic       sys_hit;
	byte_t      mem_rdata;
	logic       mem_hit;
	byte_t      ext_rdata;
	logic       ext_hit;
	logic [2:0] wram_bank;

	gb_bus_ctrl i_bus_ctrl (
		.clk_sys     (clk_sys),
		.reset_ss    (reset_ss),
		.ce_i        (ce_i),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_do_i    (cpu_do_i),
		.cpu_rd_n_i  (cpu_rd_n_i),
		.cpu_wr_n_i  (cpu_wr_n_i),
		.irq_ack_i   (irq_ack),
		.irq_vec_i   (irq_vec),
		.irq_rdata_i (irq_rdata),
		.sys_rdata_i (sys_rdata),
		.sys_hit_i   (sys_hit),
		.mem_rdata_i (mem_rdata),
		.mem_hit_i   (mem_hit),
		.ext_rdata_i (ext_rdata),
		.ext_hit_i   (ext_hit),
		.cpu_di_o    (cpu_di_o),
		.bus         (bus.master)
	);

	// joypad bit left low, its events come from joy_din
	gb_irq_ctrl i_irq_ctrl (
		.clk_sys      (clk_sys),
		.reset_ss     (reset_ss),
		.irq_lines_i  ({1'b0, serial_irq_i, timer_irq_i, video_irq_i, vblank_irq_i}),
		.joy_din_i    (joy_din_i),
		.cpu_m1_n_i   (cpu_m1_n_i),
		.cpu_iorq_n_i (cpu_iorq_n_i),
		.irq_ack_o    (irq_ack),
		.irq_vec_o    (irq_vec),
		.irq_n_o      (irq_n_o),
		.rdata_o      (irq_rdata),
		.bus          (bus.slave)
	);

	gb_sys_regs i_sys_regs (
		.clk_sys       (clk_sys),
		.reset_ss      (reset_ss),
		.is_gbc_i      (is_gbc_i),
		.cpu_stop_i    (cpu_stop_i),
		.joy_din_i     (joy_din_i),
		.rdata_o       (sys_rdata),
		.hit_o         (sys_hit),
		.gbc_mode_o    (),	// only video and hdma need the mode
		.wram_bank_o   (wram_bank),
		.speed_o       (speed_o),
		.boot_rom_en_o (boot_rom_en_o),
		.joy_p54_o     (joy_p54_o),
		.bus           (bus.slave)
	);

	gb_int_mem #(
		.WRAM_ADDR_W (WRAM_ADDR_W),
		.ZP_ADDR_W   (ZP_ADDR_W)
	) i_int_mem (
		.clk_sys     (clk_sys),
		.wram_bank_i (wram_bank),
		.rdata_o     (mem_rdata),
		.hit_o       (mem_hit),
		.bus         (bus.slave)
	);

	gb_ext_bus i_ext_bus (
		.clk_sys        (clk_sys),
		.reset_ss       (reset_ss),
		.cart_do_i      (cart_do_i),
		.cart_oe_i      (cart_oe_i),
		.ext_bus_addr_o (ext_bus_addr_o),
		.ext_bus_a15_o  (ext_bus_a15_o),
		.ncs_o          (ncs_o),
		.cart_rd_o      (cart_rd_o),
		.cart_wr_o      (cart_wr_o),
		.cart_di_o      (cart_di_o),
		.rdata_o        (ext_rdata),
		.hit_o          (ext_hit),
		.bus            (bus.slave)
	);

endmodule

// File: testbench/tb_gb_sysbus_table.svh
// stimulus and expected values, one add_row per step, included in the testbench module body
// columns: operation, address, data or slot or event index or cycles, expected, mask
task automatic build_table();
	// --------------------
	// zero page and work ram
	// --------------------
	add_row(OP_WRND,  16'hFF80, 8'd0,  8'h00, 8'h00);	// random slot 0
	add_row(OP_WRND,  16'hFFFE, 8'd1,  8'h00, 8'h00);
	add_row(OP_RDRND, 16'hFF80, 8'd0,  8'h00, 8'hFF);
	add_row(OP_RDRND, 16'hFFFE, 8'd1,  8'h00, 8'hFF);
	add_row(OP_WR,    16'hFF70, 8'h00, 8'h00, 8'h00);	// svbk 0 means bank 1
	add_row(OP_WR,    16'hD000, 8'hA5, 8'h00, 8'h00);
	add_row(OP_WR,    16'hFF70, 8'h01, 8'h00, 8'h00);
	add_row(OP_RD,    16'hFF70, 8'h00, 8'hF9, 8'hFF);
	add_row(OP_RD,    16'hD000, 8'h00, 8'hA5, 8'hFF);
	add_row(OP_WR,    16'hFF70, 8'h03, 8'h00, 8'h00);
	add_row(OP_WR,    16'hD000, 8'h3C, 8'h00, 8'h00);	// bank 3 own byte
	add_row(OP_RD,    16'hD000, 8'h00, 8'h3C, 8'hFF);
	add_row(OP_WR,    16'hFF70, 8'h01, 8'h00, 8'h00);
	add_row(OP_RD,    16'hD000, 8'h00, 8'hA5, 8'hFF);
	add_row(OP_WR,    16'hFF70, 8'h03, 8'h00, 8'h00);
	add_row(OP_RD,    16'hD000, 8'h00, 8'h3C, 8'hFF);
	add_row(OP_WRND,  16'hC000, 8'd2,  8'h00, 8'h00);
	add_row(OP_RDRND, 16'hE000, 8'd2,  8'h00, 8'hFF);	// echo area
	add_row(OP_WR,    16'hE100, 8'h77, 8'h00, 8'h00);
	add_row(OP_RD,    16'hC100, 8'h00, 8'h77, 8'hFF);

	// --------------------
	// interrupts
	// --------------------
	add_row(OP_WR,   16'hFFFF, 8'h04, 8'h00, 8'h00);	// timer only
	add_row(OP_RD,   16'hFFFF, 8'h00, 8'h04, 8'hFF);
	add_row(OP_EVT,  16'h0000, 8'd2,  8'h00, 8'h01);	// irq_n_o low
	add_row(OP_RD,   16'hFF0F, 8'h00, 8'hE4, 8'hFF);
	add_row(OP_ACK,  16'h0000, 8'h00, 8'h50, 8'hFF);
	add_row(OP_RD,   16'hFF0F, 8'h00, 8'hE0, 8'hFF);
	add_row(OP_STAT, 16'hFF0F, 8'h00, 8'h80, 8'h80);
	add_row(OP_WR,   16'hFFFF, 8'h09, 8'h00, 8'h00);	// vblank and serial
	add_row(OP_EVT,  16'h0000, 8'd3,  8'h00, 8'h01);
	add_row(OP_EVT,  16'h0000, 8'd0,  8'h00, 8'h00);	// irq already low
	add_row(OP_RD,   16'hFF0F, 8'h00, 8'hE9, 8'hFF);
	add_row(OP_ACK,  16'h0000, 8'h00, 8'h40, 8'hFF);	// lower index first
	add_row(OP_RD,   16'hFF0F, 8'h00, 8'hE8, 8'hFF);
	add_row(OP_ACK,  16'h0000, 8'h00, 8'h58, 8'hFF);
	add_row(OP_RD,   16'hFF0F, 8'h00, 8'hE0, 8'hFF);

	// --------------------
	// speed switch
	// --------------------
	add_row(OP_WR,   16'hFF4D, 8'h01, 8'h00, 8'h00);	// prepare
	add_row(OP_RD,   16'hFF4D, 8'h00, 8'h7F, 8'hFF);
	add_row(OP_STOP, 16'h0000, 8'h00, 8'h01, 8'h01);
	add_row(OP_RD,   16'hFF4D, 8'h00, 8'hFE, 8'hFF);

	// --------------------
	// joypad
	// --------------------
	add_row(OP_WR,   16'hFF00, 8'h20, 8'h00, 8'h00);	// p54 = 10
	add_row(OP_STAT, 16'hFF00, 8'h00, 8'h08, 8'h0C);
	add_row(OP_RD,   16'hFF00, 8'h00, 8'hEF, 8'hFF);
	add_row(OP_WR,   16'hFFFF, 8'h10, 8'h00, 8'h00);
	add_row(OP_JOY,  16'h0000, 8'h0E, 8'h00, 8'h01);	// key 0 pressed
	add_row(OP_RD,   16'hFF0F, 8'h00, 8'hF0, 8'hFF);
	add_row(OP_RD,   16'hFF00, 8'h00, 8'hEE, 8'hFF);
	add_row(OP_ACK,  16'h0000, 8'h00, 8'h60, 8'hFF);
	add_row(OP_JOY,  16'h0000, 8'h0F, 8'h00, 8'h00);

	// --------------------
	// mode and boot rom
	// --------------------
	add_row(OP_RD,   16'hFF50, 8'h00, 8'h00, 8'hFF);
	add_row(OP_WR,   16'hFF4C, 8'h04, 8'h00, 8'h00);	// mono compatible
	add_row(OP_RD,   16'hFF4C, 8'h00, 8'hF6, 8'hFF);
	add_row(OP_STAT, 16'hFF4C, 8'h00, 8'h02, 8'h02);
	add_row(OP_RD,   16'hFF70, 8'h00, 8'hFB, 8'hFF);	// boot rom keeps colour mode
	add_row(OP_WR,   16'hFF50, 8'h11, 8'h00, 8'h00);
	add_row(OP_STAT, 16'hFF50, 8'h00, 8'h00, 8'h02);
	add_row(OP_RD,   16'hFF70, 8'h00, 8'hFF, 8'hFF);
	add_row(OP_WR,   16'hFF4C, 8'h00, 8'h00, 8'h00);	// locked now
	add_row(OP_RD,   16'hFF70, 8'h00, 8'hFF, 8'hFF);
	add_row(OP_RD,   16'hFF4C, 8'h00, 8'hFF, 8'hFF);

	// --------------------
	// cartridge bus
	// --------------------
	add_row(OP_CART, 16'h0001, 8'h5A, 8'h00, 8'h00);
	add_row(OP_RD,   16'h0123, 8'h00, 8'h5A, 8'hFF);
	add_row(OP_STAT, 16'h0123, 8'h00, 8'h20, 8'h20);
	add_row(OP_STAT, 16'hA000, 8'h00, 8'h00, 8'h10);
	add_row(OP_STAT, 16'hA000, 8'h00, 8'h40, 8'h40);
	add_row(OP_STAT, 16'h0123, 8'h00, 8'h10, 8'h10);
	add_row(OP_CART, 16'h0000, 8'h5A, 8'h00, 8'h00);	// cart lets go
	add_row(OP_RD,   16'h0123, 8'h00, 8'h5A, 8'hFF);
	add_row(OP_IDLE, 16'h0000, 8'd4,  8'h00, 8'h00);
	add_row(OP_RD,   16'h0123, 8'h00, 8'hFF, 8'hFF);
	add_row(OP_CWR,  16'hA5C3, 8'h6C, 8'h00, 8'h00);	// cart ram write

	// --------------------
	// spare registers
	// --------------------
	add_row(OP_WRND,  16'hFF72, 8'd3,  8'h00, 8'h00);
	add_row(OP_RDRND, 16'hFF72, 8'd3,  8'h00, 8'hFF);
	add_row(OP_WR,    16'hFF75, 8'h25, 8'h00, 8'h00);
	add_row(OP_RD,    16'hFF75, 8'h00, 8'hAF, 8'hFF);
	add_row(OP_RD,    16'hFF7F, 8'h00, 8'hFF, 8'hFF);	// nothing mapped
endtask

// File: testbench/tb_gb_sysbus.sv
// testbench for the system bus glue, applies the stimulus table to the DUT and reports per row
`timescale 1ns/1ps

module tb_gb_sysbus;

	localparam int EVT_TIMEOUT = 8;	// cycles until irq_n_o must move
	localparam int JOY_CYCLES  = 3;	// two-stage joypad sampling
	localparam int WATCHDOG_NS = 200000;

	typedef enum logic [3:0] {
		OP_WR, OP_WRND, OP_RD, OP_RDRND, OP_EVT, OP_ACK,
		OP_STOP, OP_JOY, OP_STAT, OP_CART, OP_CWR, OP_IDLE
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [15:0] addr;
		logic [7:0]  data;	// also random slot, event index, cycles
		logic [7:0]  exp;
		logic [7:0]  mask;
	} row_t;

	logic        clk_sys = 1'b0;
	logic        reset_ss;
	logic        ce_i;
	logic        is_gbc_i;
	logic [15:0] cpu_addr_i;
	logic [7:0]  cpu_do_i;
	logic        cpu_rd_n_i;
	logic        cpu_wr_n_i;
	logic        cpu_m1_n_i;
	logic        cpu_iorq_n_i;
	logic        cpu_stop_i;
	logic [3:0]  evt_lines;	// vblank, video, timer, serial
	logic [3:0]  joy_din_i;
	logic [7:0]  cart_do_i;
	logic        cart_oe_i;
	logic [7:0]  cpu_di_o;
	logic        irq_n_o;
	logic        speed_o;
	logic        boot_rom_en_o;
	logic [1:0]  joy_p54_o;
	logic [14:0] ext_bus_addr_o;
	logic        ext_bus_a15_o;
	logic        ncs_o;
	logic        cart_rd_o;
	logic        cart_wr_o;
	logic [7:0]  cart_di_o;

	row_t        rows [$];
	logic [7:0]  rnd [4];	// random bytes, one per slot
	int          checks;
	int          errors;
	logic        row_ok;

	gb_sysbus i_gb_sysbus (
		.clk_sys        (clk_sys),
		.reset_ss       (reset_ss),
		.ce_i           (ce_i),
		.is_gbc_i       (is_gbc_i),
		.cpu_addr_i     (cpu_addr_i),
		.cpu_do_i       (cpu_do_i),
		.cpu_rd_n_i     (cpu_rd_n_i),
		.cpu_wr_n_i     (cpu_wr_n_i),
		.cpu_m1_n_i     (cpu_m1_n_i),
		.cpu_iorq_n_i   (cpu_iorq_n_i),
		.cpu_stop_i     (cpu_stop_i),
		.vblank_irq_i   (evt_lines[0]),
		.video_irq_i    (evt_lines[1]),
		.timer_irq_i    (evt_lines[2]),
		.serial_irq_i   (evt_lines[3]),
		.joy_din_i      (joy_din_i),
		.cart_do_i      (cart_do_i),
		.cart_oe_i      (cart_oe_i),
		.cpu_di_o       (cpu_di_o),
		.irq_n_o        (irq_n_o),
		.speed_o        (speed_o),
		.boot_rom_en_o  (boot_rom_en_o),
		.joy_p54_o      (joy_p54_o),
		.ext_bus_addr_o (ext_bus_addr_o),
		.ext_bus_a15_o  (ext_bus_a15_o),
		.ncs_o          (ncs_o),
		.cart_rd_o      (cart_rd_o),
		.cart_wr_o      (cart_wr_o),
		.cart_di_o      (cart_di_o)
	);

	always #20 clk_sys = ~clk_sys;	// 40 ns period

	// --------------------
	// helpers
	// --------------------
	task automatic add_row(input op_e op, input logic [15:0] addr, input logic [7:0] data,
	                       input logic [7:0] exp, input logic [7:0] mask);
		row_t r;
		r.op   = op;
		r.addr = addr;
		r.data = data;
		r.exp  = exp;
		r.mask = mask;
		rows.push_back(r);
	endtask

	task automatic check_byte(input string name, input logic [7:0] got,
	                          input logic [7:0] exp, input logic [7:0] mask);
		checks++;
		assert ((got & mask) === (exp & mask)) else begin
			$display("MISMATCH %s: got %h, expected %h, mask %h", name, got & mask,
			         exp & mask, mask);
			errors++;
			row_ok = 1'b0;
		end
	endtask

	// pins packed for the status rows
	function automatic logic [7:0] status_word();
		return {irq_n_o, ext_bus_a15_o, cart_rd_o, ncs_o, joy_p54_o, boot_rom_en_o, speed_o};
	endfunction

	function automatic string status_name(input logic [7:0] mask);
		case (mask)
			8'h01:   return "speed_o";
			8'h02:   return "boot_rom_en_o";
			8'h0C:   return "joy_p54_o";
			8'h10:   return "ncs_o";
			8'h20:   return "cart_rd_o";
			8'h40:   return "ext_bus_a15_o";
			8'h80:   return "irq_n_o";
			default: return "status";
		endcase
	endfunction

	task automatic write_byte(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		cpu_addr_i <= addr;
		cpu_do_i   <= data;
		cpu_wr_n_i <= 1'b0;
		@(posedge clk_sys);	// strobe cycle ends here
		cpu_wr_n_i <= 1'b1;
	endtask

	// cartridge write, pins sampled inside the strobe cycle
	task automatic write_cart(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		cpu_addr_i <= addr;
		cpu_do_i   <= data;
		cpu_wr_n_i <= 1'b0;
		@(negedge clk_sys);
		check_byte("cart_wr_o", {7'd0, cart_wr_o}, 8'h01, 8'h01);
		check_byte("cart_di_o", cart_di_o, data, 8'hFF);
		check_byte("ext_bus_addr_o[7:0]", ext_bus_addr_o[7:0], addr[7:0], 8'hFF);
		check_byte("ext_bus_addr_o[14:8]", {1'b0, ext_bus_addr_o[14:8]}, {1'b0, addr[14:8]},
		           8'h7F);
		@(posedge clk_sys);
		cpu_wr_n_i <= 1'b1;
		@(negedge clk_sys);
		check_byte("cart_wr_o", {7'd0, cart_wr_o}, 8'h00, 8'h01);	// one cycle only
	endtask

	// address held three cycles, sampled in the last
	task automatic read_byte(input logic [15:0] addr, output logic [7:0] data,
	                         output logic [7:0] stat);
		@(posedge clk_sys);
		cpu_addr_i <= addr;
		cpu_rd_n_i <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		data = cpu_di_o;
		stat = status_word();
		@(posedge clk_sys);
		cpu_rd_n_i <= 1'b1;
	endtask

	task automatic wait_irq(input logic level, input int limit);
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (irq_n_o !== level && n < limit);
		checks++;
		assert (irq_n_o === level) else begin
			$display("timeout: irq_n_o did not reach %0d within %0d cycles", level, limit);
			errors++;
			row_ok = 1'b0;
		end
	endtask

	task automatic pulse_event(input logic [1:0] idx);
		@(posedge clk_sys);
		evt_lines[idx] <= 1'b1;
		@(posedge clk_sys);
		evt_lines[idx] <= 1'b0;
	endtask

	task automatic ack_cycle(input logic [7:0] exp, input logic [7:0] mask);
		@(posedge clk_sys);
		cpu_iorq_n_i <= 1'b0;
		cpu_m1_n_i   <= 1'b0;
		@(negedge clk_sys);
		check_byte("cpu_di_o", cpu_di_o, exp, mask);	// vector on the bus
		@(posedge clk_sys);
		cpu_iorq_n_i <= 1'b1;
		cpu_m1_n_i   <= 1'b1;
		@(posedge clk_sys);	// top pending flag clears here
	endtask

	task automatic apply_row(input row_t r);
		logic [7:0] got;
		logic [7:0] stat;
		case (r.op)
			OP_WR: write_byte(r.addr, r.data);
			OP_WRND: begin
				rnd[r.data[1:0]] = 8'($urandom);
				write_byte(r.addr, rnd[r.data[1:0]]);
			end
			OP_RD: begin
				read_byte(r.addr, got, stat);
				check_byte("cpu_di_o", got, r.exp, r.mask);
			end
			OP_RDRND: begin
				read_byte(r.addr, got, stat);
				check_byte("cpu_di_o", got, rnd[r.data[1:0]], 8'hFF);
			end
			OP_STAT: begin
				read_byte(r.addr, got, stat);
				check_byte(status_name(r.mask), stat, r.exp, r.mask);
			end
			OP_EVT: begin
				pulse_event(r.data[1:0]);
				if (r.mask[0])
					wait_irq(r.exp[0], EVT_TIMEOUT);
			end
			OP_ACK: ack_cycle(r.exp, r.mask);
			OP_STOP: begin
				@(posedge clk_sys);
				cpu_stop_i <= 1'b1;
				@(posedge clk_sys);
				cpu_stop_i <= 1'b0;
				@(negedge clk_sys);
				check_byte("speed_o", status_word(), r.exp, r.mask);
			end
			OP_JOY: begin
				@(posedge clk_sys);
				joy_din_i <= r.data[3:0];
				if (r.mask[0])
					wait_irq(r.exp[0], JOY_CYCLES);
			end
			OP_CART: begin
				@(posedge clk_sys);
				cart_do_i <= r.data;
				cart_oe_i <= r.addr[0];	// addr bit 0 carries oe
			end
			OP_CWR: write_cart(r.addr, r.data);
			OP_IDLE: repeat (r.data) @(posedge clk_sys);
			default: begin
				$display("table row has an unknown operation");
				errors++;
				row_ok = 1'b0;
			end
		endcase
	endtask

	`include "tb_gb_sysbus_table.svh"

	// --------------------
	// main sequence
	// --------------------
	initial begin
		row_t cur;
		void'($urandom(22));
		reset_ss     <= 1'b1;
		ce_i         <= 1'b1;	// full rate bus
		is_gbc_i     <= 1'b1;
		cpu_addr_i   <= 16'h0000;
		cpu_do_i     <= 8'h00;
		cpu_rd_n_i   <= 1'b1;
		cpu_wr_n_i   <= 1'b1;
		cpu_m1_n_i   <= 1'b1;
		cpu_iorq_n_i <= 1'b1;
		cpu_stop_i   <= 1'b0;
		evt_lines    <= 4'h0;
		joy_din_i    <= 4'hF;	// no key pressed
		cart_do_i    <= 8'hFF;
		cart_oe_i    <= 1'b0;
		checks       = 0;
		errors       = 0;
		build_table();
		repeat (3) @(posedge clk_sys);
		reset_ss <= 1'b0;
		repeat (2) @(posedge clk_sys);
		foreach (rows[i]) begin
			cur    = rows[i];
			row_ok = 1'b1;
			apply_row(cur);
			$display("row %0d %s addr %h: %s", i, cur.op.name(), cur.addr,
			         row_ok ? "ok" : "FAIL");
		end
		$display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: the run did not finish in time");
		$display("*** FAILED ***");
		$finish;
	end

endmodule
